// File: source/mipsCtrlPkg.sv
package mipsCtrlPkg;

    localparam int InstrW  = 32;
    localparam int OpcodeW = 6;
    localparam int FunctW  = 6;
    localparam int RegIdxW = 5;
    localparam int AluOpW  = 5;

    // major opcodes, instr[31:26]
    localparam logic [OpcodeW-1:0] OpSpecial  = 6'b000000;
    localparam logic [OpcodeW-1:0] OpRegimm   = 6'b000001;
    localparam logic [OpcodeW-1:0] OpJ        = 6'b000010;
    localparam logic [OpcodeW-1:0] OpJal      = 6'b000011;
    localparam logic [OpcodeW-1:0] OpBeq      = 6'b000100;
    localparam logic [OpcodeW-1:0] OpBne      = 6'b000101;
    localparam logic [OpcodeW-1:0] OpBlez     = 6'b000110;
    localparam logic [OpcodeW-1:0] OpBgtz     = 6'b000111;
    localparam logic [OpcodeW-1:0] OpAddi     = 6'b001000;
    localparam logic [OpcodeW-1:0] OpAddiu    = 6'b001001;
    localparam logic [OpcodeW-1:0] OpSlti     = 6'b001010;
    localparam logic [OpcodeW-1:0] OpSltiu    = 6'b001011;
    localparam logic [OpcodeW-1:0] OpAndi     = 6'b001100;
    localparam logic [OpcodeW-1:0] OpOri      = 6'b001101;
    localparam logic [OpcodeW-1:0] OpXori     = 6'b001110;
    localparam logic [OpcodeW-1:0] OpLui      = 6'b001111;
    localparam logic [OpcodeW-1:0] OpSpecial2 = 6'b011100;
    localparam logic [OpcodeW-1:0] OpSpecial3 = 6'b011111;
    localparam logic [OpcodeW-1:0] OpLb       = 6'b100000;
    localparam logic [OpcodeW-1:0] OpLh       = 6'b100001;
    localparam logic [OpcodeW-1:0] OpLw       = 6'b100011;
    localparam logic [OpcodeW-1:0] OpSb       = 6'b101000;
    localparam logic [OpcodeW-1:0] OpSh       = 6'b101001;
    localparam logic [OpcodeW-1:0] OpSw       = 6'b101011;

    // SPECIAL funct codes
    localparam logic [FunctW-1:0] FnSll   = 6'b000000;
    localparam logic [FunctW-1:0] FnSrl   = 6'b000010; // rotr when bit 21 set
    localparam logic [FunctW-1:0] FnSra   = 6'b000011;
    localparam logic [FunctW-1:0] FnSllv  = 6'b000100;
    localparam logic [FunctW-1:0] FnSrlv  = 6'b000110; // rotrv when bit 6 set
    localparam logic [FunctW-1:0] FnSrav  = 6'b000111;
    localparam logic [FunctW-1:0] FnJr    = 6'b001000;
    localparam logic [FunctW-1:0] FnMovz  = 6'b001010;
    localparam logic [FunctW-1:0] FnMovn  = 6'b001011;
    localparam logic [FunctW-1:0] FnMfhi  = 6'b010000;
    localparam logic [FunctW-1:0] FnMthi  = 6'b010001;
    localparam logic [FunctW-1:0] FnMflo  = 6'b010010;
    localparam logic [FunctW-1:0] FnMtlo  = 6'b010011;
    localparam logic [FunctW-1:0] FnMult  = 6'b011000;
    localparam logic [FunctW-1:0] FnMultu = 6'b011001;
    localparam logic [FunctW-1:0] FnAdd   = 6'b100000;
    localparam logic [FunctW-1:0] FnAddu  = 6'b100001;
    localparam logic [FunctW-1:0] FnSub   = 6'b100010;
    localparam logic [FunctW-1:0] FnAnd   = 6'b100100;
    localparam logic [FunctW-1:0] FnOr    = 6'b100101;
    localparam logic [FunctW-1:0] FnXor   = 6'b100110;
    localparam logic [FunctW-1:0] FnNor   = 6'b100111;
    localparam logic [FunctW-1:0] FnSlt   = 6'b101010;
    localparam logic [FunctW-1:0] FnSltu  = 6'b101011;
    // SPECIAL2 funct codes
    localparam logic [FunctW-1:0] FnMadd  = 6'b000000;
    localparam logic [FunctW-1:0] FnMul   = 6'b000010;
    localparam logic [FunctW-1:0] FnMsub  = 6'b000100;
    // SPECIAL3 selects on the shamt field
    localparam logic [RegIdxW-1:0] SaSeh  = 5'b11000;
    localparam logic [RegIdxW-1:0] SaSeb  = 5'b10000;
    // REGIMM selects on rt
    localparam logic [RegIdxW-1:0] RtBltz = 5'b00000;
    localparam logic [RegIdxW-1:0] RtBgez = 5'b00001;

    // memory access size
    localparam logic [1:0] AddrWord = 2'd0;
    localparam logic [1:0] AddrHalf = 2'd1;
    localparam logic [1:0] AddrByte = 2'd2;

    typedef struct packed {
        logic [OpcodeW-1:0] opcode;
        logic [RegIdxW-1:0] rs;
        logic [RegIdxW-1:0] rt;
        logic [RegIdxW-1:0] rd;
        logic [RegIdxW-1:0] shamt;
        logic [FunctW-1:0]  funct;
    } rTypeT;

    typedef struct packed {
        logic [OpcodeW-1:0]                  opcode;
        logic [RegIdxW-1:0]                  rs;
        logic [RegIdxW-1:0]                  rt;
        logic [InstrW-OpcodeW-2*RegIdxW-1:0] imm16;
    } iTypeT;

    typedef union packed {
        rTypeT rType;
        iTypeT iType;
    } instrWordU;

    typedef enum logic [AluOpW-1:0] {
        AluNone = 5'd0,  AluAdd   = 5'd1,  AluAddu  = 5'd2,  AluSub  = 5'd3,
        AluMul  = 5'd4,  AluMult  = 5'd5,  AluMultu = 5'd6,  AluMadd = 5'd7,
        AluMsub = 5'd8,  AluLui   = 5'd9,  AluMthi  = 5'd10, AluMtlo = 5'd11,
        AluMfhi = 5'd12, AluMflo  = 5'd13, AluSra   = 5'd15, AluAnd  = 5'd16,
        AluOr   = 5'd17, AluNor   = 5'd18, AluXor   = 5'd19, AluSll  = 5'd20,
        AluSrl  = 5'd21, AluSlt   = 5'd22, AluMov   = 5'd23, AluRotrv = 5'd24,
        AluSrav = 5'd25, AluSeb   = 5'd26, AluSltu  = 5'd27, AluSeh  = 5'd28,
        AluSllv = 5'd29, AluSrlv  = 5'd30, AluRotr  = 5'd31
    } aluOpE;

    typedef struct packed {
        logic [1:0] addrType; // 0 word, 1 half, 2 byte
        logic       memWrite;
        logic       memRead;
        logic       memToReg;
    } memCtrlT;

    typedef enum logic [3:0] {
        BrNone, BrBeq, BrBne, BrBgtz, BrBlez, BrBgez, BrBltz, BrJr, BrMovn, BrMovz
    } branchKindE;

    typedef enum logic [1:0] {
        JmpNone = 2'd0,
        JmpJ    = 2'd1,
        JmpReg  = 2'd2,
        JmpLink = 2'd3
    } jumpKindE;

    typedef struct packed {
        logic       aluSrc;
        aluOpE      aluOp;
        logic       regDst;
        logic       regWrite; // movn/movz still gated at resolve
        memCtrlT    mem;
        branchKindE branchKind;
        jumpKindE   jumpKind;
    } ctrlBundleT;

    typedef struct packed {
        logic equalVal;
        logic gtZero;
        logic ltZero;
        logic beqz; // rt == 0, for movn/movz
    } cmpFlagsT;

    typedef struct packed {
        logic     aluSrc;
        aluOpE    aluOp;
        logic     regDst;
        logic     regWrite;
        memCtrlT  mem;
        jumpKindE jumpKind;
        logic     pcSrc;
        logic     branch;
    } resolvedCtrlT;

endpackage

// File: source/instrDecoder.sv
`timescale 1ns/1ps
module instrDecoder (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    inValid,
    input  mipsCtrlPkg::instrWordU  instr,
    output logic                    inReady,
    output logic                    decValid,
    input  logic                    decReady,
    output mipsCtrlPkg::ctrlBundleT decCtrl
);
    import mipsCtrlPkg::*;

    ctrlBundleT nextCtrl; // combinational decode of instr
    logic       accept;

    function automatic ctrlBundleT aluCtrl(input logic src, input aluOpE op,
                                           input logic dst, input logic wr);
        ctrlBundleT c;
        c          = '0;
        c.aluSrc   = src;
        c.aluOp    = op;
        c.regDst   = dst;
        c.regWrite = wr;
        return c;
    endfunction

    function automatic ctrlBundleT rCtrl(input aluOpE op);
        return aluCtrl(1'b0, op, 1'b1, 1'b1); // reg-reg, writes rd
    endfunction

    function automatic ctrlBundleT iCtrl(input aluOpE op);
        return aluCtrl(1'b1, op, 1'b0, 1'b1); // imm operand, writes rt
    endfunction

    function automatic ctrlBundleT memCtrl(input logic [1:0] size, input logic isLoad);
        ctrlBundleT c;
        c              = aluCtrl(1'b1, AluAdd, 1'b0, isLoad); // base + offset
        c.mem.addrType = size;
        c.mem.memWrite = ~isLoad;
        c.mem.memRead  = isLoad;
        c.mem.memToReg = isLoad;
        return c;
    endfunction

    always_comb begin
        nextCtrl = '0; // unknown encodings fall through as all-zero
        case (instr.rType.opcode)
            OpSpecial: begin
                case (instr.rType.funct)
                    FnAdd:   nextCtrl = rCtrl(AluAdd);
                    FnAddu:  nextCtrl = rCtrl(AluAddu);
                    FnSub:   nextCtrl = rCtrl(AluSub);
                    FnMult:  nextCtrl = rCtrl(AluMult);
                    FnMultu: nextCtrl = rCtrl(AluMultu);
                    FnAnd:   nextCtrl = rCtrl(AluAnd);
                    FnOr:    nextCtrl = rCtrl(AluOr);
                    FnNor:   nextCtrl = rCtrl(AluNor);
                    FnXor:   nextCtrl = rCtrl(AluXor);
                    FnSll:   nextCtrl = (instr == '0) ? '0 : rCtrl(AluSll); // zero word is nop
                    FnSrl:   nextCtrl = rCtrl(instr.rType.rs[0] ? AluRotr : AluSrl);
                    FnSllv:  nextCtrl = rCtrl(AluSllv);
                    FnSrlv:  nextCtrl = rCtrl(instr.rType.shamt[0] ? AluRotrv : AluSrlv);
                    FnSra:   nextCtrl = rCtrl(AluSra);
                    FnSrav:  nextCtrl = rCtrl(AluSrav);
                    FnSlt:   nextCtrl = rCtrl(AluSlt);
                    FnSltu:  nextCtrl = rCtrl(AluSltu);
                    FnMthi:  nextCtrl = aluCtrl(1'b0, AluMthi, 1'b0, 1'b0); // hi/lo only
                    FnMtlo:  nextCtrl = aluCtrl(1'b0, AluMtlo, 1'b0, 1'b0);
                    FnMfhi:  nextCtrl = rCtrl(AluMfhi);
                    FnMflo:  nextCtrl = rCtrl(AluMflo);
                    FnMovn: begin
                        nextCtrl            = rCtrl(AluMov);
                        nextCtrl.branchKind = BrMovn; // write decided on beqz later
                    end
                    FnMovz: begin
                        nextCtrl            = rCtrl(AluMov);
                        nextCtrl.branchKind = BrMovz;
                    end
                    FnJr: begin
                        nextCtrl            = aluCtrl(1'b0, AluAdd, 1'b0, 1'b0);
                        nextCtrl.branchKind = BrJr;
                        nextCtrl.jumpKind   = JmpReg;
                    end
                    default: nextCtrl = '0;
                endcase
            end
            OpSpecial2: begin
                case (instr.rType.funct)
                    FnMul:   nextCtrl = rCtrl(AluMul);
                    FnMadd:  nextCtrl = rCtrl(AluMadd);
                    FnMsub:  nextCtrl = rCtrl(AluMsub);
                    default: nextCtrl = '0;
                endcase
            end
            OpSpecial3: begin
                case (instr.rType.shamt) // bshfl sub-op sits in the shamt slot
                    SaSeh:   nextCtrl = rCtrl(AluSeh);
                    SaSeb:   nextCtrl = rCtrl(AluSeb);
                    default: nextCtrl = '0;
                endcase
            end
            OpRegimm: begin
                case (instr.iType.rt)
                    RtBltz:  nextCtrl.branchKind = BrBltz;
                    RtBgez:  nextCtrl.branchKind = BrBgez;
                    default: nextCtrl = '0;
                endcase
            end
            OpAddi:  nextCtrl = iCtrl(AluAdd);
            OpAddiu: nextCtrl = iCtrl(AluAddu);
            OpAndi:  nextCtrl = iCtrl(AluAnd);
            OpOri:   nextCtrl = iCtrl(AluOr);
            OpXori:  nextCtrl = iCtrl(AluXor);
            OpSlti:  nextCtrl = iCtrl(AluSlt);
            OpSltiu: nextCtrl = iCtrl(AluSltu);
            OpLui:   nextCtrl = iCtrl(AluLui);
            OpLw:    nextCtrl = memCtrl(AddrWord, 1'b1);
            OpLh:    nextCtrl = memCtrl(AddrHalf, 1'b1);
            OpLb:    nextCtrl = memCtrl(AddrByte, 1'b1);
            OpSw:    nextCtrl = memCtrl(AddrWord, 1'b0);
            OpSh:    nextCtrl = memCtrl(AddrHalf, 1'b0);
            OpSb:    nextCtrl = memCtrl(AddrByte, 1'b0);
            OpBeq:   nextCtrl.branchKind = BrBeq;
            OpBne:   nextCtrl.branchKind = BrBne;
            OpBgtz:  nextCtrl.branchKind = BrBgtz;
            OpBlez:  nextCtrl.branchKind = BrBlez;
            OpJ:     nextCtrl.jumpKind = JmpJ;
            OpJal: begin
                nextCtrl.jumpKind = JmpLink;
                nextCtrl.regWrite = 1'b1; // link into $ra
            end
            default: nextCtrl = '0;
        endcase
    end

    assign inReady = ~decValid | decReady; // empty, or draining this cycle
    assign accept  = inValid & inReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid <= 1'b0;
        end else if (accept) begin
            decValid <= 1'b1;
        end else if (decReady) begin
            decValid <= 1'b0; // drained, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            decCtrl <= nextCtrl;
        end
    end

endmodule

// File: source/ctrlQueue.sv
`timescale 1ns/1ps
module ctrlQueue (
    input  logic                    clk,
    input  logic                    rstN,
    input  logic                    decValid,
    input  mipsCtrlPkg::ctrlBundleT decCtrl,
    output logic                    decReady,
    output logic                    headValid,
    output mipsCtrlPkg::ctrlBundleT headCtrl,
    input  logic                    headReady
);
    import mipsCtrlPkg::*;

    ctrlBundleT entry [2]; // storage, two slots
    logic       wrPtr;
    logic       rdPtr;
    logic [1:0] count;     // 0..2
    logic       wrEn;
    logic       rdEn;

    assign headValid = (count != 2'd0);
    assign headCtrl  = entry[rdPtr];

    // full queue still takes a word when the head leaves this cycle
    assign decReady = (count != 2'd2) | headReady;

    assign wrEn = decValid & decReady;
    assign rdEn = headValid & headReady;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= 1'b0;
            rdPtr <= 1'b0;
            count <= 2'd0;
        end else begin
            wrPtr <= wrPtr ^ wrEn;
            rdPtr <= rdPtr ^ rdEn;
            count <= count + {1'b0, wrEn} - {1'b0, rdEn};
        end
    end

    always_ff @(posedge clk) begin
        if (wrEn) begin
            entry[wrPtr] <= decCtrl;
        end
    end

endmodule

// File: source/branchResolver.sv
`timescale 1ns/1ps
module branchResolver (
    input  mipsCtrlPkg::ctrlBundleT   headCtrl,
    input  mipsCtrlPkg::cmpFlagsT     cmpFlags,
    output mipsCtrlPkg::resolvedCtrlT outCtrl
);
    import mipsCtrlPkg::*;

    always_comb begin
        // pass-through fields
        outCtrl.aluSrc   = headCtrl.aluSrc;
        outCtrl.aluOp    = headCtrl.aluOp;
        outCtrl.regDst   = headCtrl.regDst;
        outCtrl.regWrite = headCtrl.regWrite;
        outCtrl.mem      = headCtrl.mem;
        outCtrl.jumpKind = headCtrl.jumpKind;
        outCtrl.pcSrc    = 1'b0;
        outCtrl.branch   = 1'b0;

        case (headCtrl.branchKind)
            BrBeq: begin
                outCtrl.branch = 1'b1;
                outCtrl.pcSrc  = cmpFlags.equalVal;
            end
            BrBne: begin
                outCtrl.branch = 1'b1;
                outCtrl.pcSrc  = ~cmpFlags.equalVal;
            end
            BrBgtz: begin
                outCtrl.branch = 1'b1;
                outCtrl.pcSrc  = cmpFlags.gtZero;
            end
            BrBlez: begin
                outCtrl.branch = 1'b1;
                outCtrl.pcSrc  = ~cmpFlags.gtZero; // <= 0
            end
            BrBgez: begin
                outCtrl.branch = 1'b1;
                outCtrl.pcSrc  = ~cmpFlags.ltZero; // >= 0
            end
            BrBltz: begin
                outCtrl.branch = 1'b1;
                outCtrl.pcSrc  = cmpFlags.ltZero;
            end
            BrJr:    outCtrl.branch = 1'b1; // target from register, pcSrc stays 0
            BrMovn:  outCtrl.regWrite = headCtrl.regWrite & ~cmpFlags.beqz; // rt != 0
            BrMovz:  outCtrl.regWrite = headCtrl.regWrite & cmpFlags.beqz;  // rt == 0
            default: outCtrl.branch = 1'b0;
        endcase
    end

endmodule

// File: source/mipsControlUnit.sv
`timescale 1ns/1ps
module mipsControlUnit (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      inValid,
    input  mipsCtrlPkg::instrWordU    instr,
    output logic                      inReady,
    output logic                      outValid,
    input  logic                      outReady,
    input  mipsCtrlPkg::cmpFlagsT     cmpFlags,
    output mipsCtrlPkg::resolvedCtrlT outCtrl
);
    import mipsCtrlPkg::*;

    logic       decValid;  // decoder register -> queue
    logic       decReady;
    ctrlBundleT decCtrl;
    ctrlBundleT headCtrl;  // queue head -> resolver

    instrDecoder instrDecoder_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .instr    (instr),
        .inReady  (inReady),
        .decValid (decValid),
        .decReady (decReady),
        .decCtrl  (decCtrl)
    );

    ctrlQueue ctrlQueue_inst (
        .clk       (clk),
        .rstN      (rstN),
        .decValid  (decValid),
        .decCtrl   (decCtrl),
        .decReady  (decReady),
        .headValid (outValid), // head valid is the output valid
        .headCtrl  (headCtrl),
        .headReady (outReady)
    );

    branchResolver branchResolver_inst (
        .headCtrl (headCtrl),
        .cmpFlags (cmpFlags),
        .outCtrl  (outCtrl)
    );

endmodule

// File: dv/clockGen.sv
`timescale 1ns/1ps
module clockGen (
    output logic clk,
    output logic rstN
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk; // 4 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (3) @(posedge clk); // three reset edges
        @(negedge clk);
        rstN = 1'b1; // released on a falling edge
    end
endmodule

// File: dv/tbTests.svh
function automatic logic [31:0] rWord(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [4:0] rd,
                                      input logic [4:0] sa, input logic [5:0] fn);
    return {op, rs, rt, rd, sa, fn};
endfunction

function automatic logic [31:0] iWord(input logic [5:0] op, input logic [4:0] rs,
                                      input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

function automatic resolvedCtrlT aluExpect(input logic src, input aluOpE op,
                                           input logic dst, input logic wr);
    resolvedCtrlT e;
    e          = '0;
    e.aluSrc   = src;
    e.aluOp    = op;
    e.regDst   = dst;
    e.regWrite = wr;
    return e;
endfunction

// loads read and write back, stores only write memory
function automatic resolvedCtrlT memExpect(input logic [1:0] size, input logic isLoad);
    resolvedCtrlT e;
    e              = aluExpect(1'b1, AluAdd, 1'b0, isLoad);
    e.mem.addrType = size;
    if (isLoad) begin
        e.mem.memRead  = 1'b1;
        e.mem.memToReg = 1'b1;
    end else begin
        e.mem.memWrite = 1'b1;
    end
    return e;
endfunction

function automatic resolvedCtrlT flowExpect(input jumpKindE jk, input logic wr,
                                            input logic br, input logic pc);
    resolvedCtrlT e;
    e          = '0;
    e.jumpKind = jk;
    e.regWrite = wr;
    e.branch   = br;
    e.pcSrc    = pc;
    return e;
endfunction

task automatic addKnown(input string name, input logic [31:0] word, input resolvedCtrlT e);
    knownName.push_back(name);
    knownWord.push_back(word);
    knownExp.push_back(e);
endtask

task automatic loadKnownTable();
    addKnown("add", rWord(OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, FnAdd), aluExpect(0, AluAdd, 1, 1));
    addKnown("sub", rWord(OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, FnSub), aluExpect(0, AluSub, 1, 1));
    addKnown("sll", rWord(OpSpecial, 5'd0, 5'd2, 5'd3, 5'd4, FnSll), aluExpect(0, AluSll, 1, 1));
    addKnown("rotr", rWord(OpSpecial, 5'd1, 5'd2, 5'd3, 5'd4, FnSrl),
             aluExpect(0, AluRotr, 1, 1)); // rs lsb is bit 21
    addKnown("addiu", iWord(OpAddiu, 5'd1, 5'd2, 16'h0010), aluExpect(1, AluAddu, 0, 1));
    addKnown("lui", iWord(OpLui, 5'd0, 5'd2, 16'h1234), aluExpect(1, AluLui, 0, 1));
    addKnown("mul", rWord(OpSpecial2, 5'd1, 5'd2, 5'd3, 5'd0, FnMul), aluExpect(0, AluMul, 1, 1));
    addKnown("seh", rWord(OpSpecial3, 5'd0, 5'd2, 5'd3, SaSeh, 6'b100000),
             aluExpect(0, AluSeh, 1, 1)); // bshfl funct
    addKnown("nop", 32'h0, '0);
    addKnown("lw", iWord(OpLw, 5'd1, 5'd2, 16'h0004), memExpect(AddrWord, 1'b1));
    addKnown("lh", iWord(OpLh, 5'd1, 5'd2, 16'h0006), memExpect(AddrHalf, 1'b1));
    addKnown("lb", iWord(OpLb, 5'd1, 5'd2, 16'h0007), memExpect(AddrByte, 1'b1));
    addKnown("sw", iWord(OpSw, 5'd1, 5'd2, 16'h0008), memExpect(AddrWord, 1'b0));
    addKnown("sh", iWord(OpSh, 5'd1, 5'd2, 16'h000a), memExpect(AddrHalf, 1'b0));
    addKnown("sb", iWord(OpSb, 5'd1, 5'd2, 16'h000b), memExpect(AddrByte, 1'b0));
    fullMask          = '1;
    flowMask          = '0;
    flowMask.regWrite = 1'b1;
    flowMask.mem      = '1;
    flowMask.jumpKind = JmpLink; // both bits set
    flowMask.pcSrc    = 1'b1;
    flowMask.branch   = 1'b1;
endtask

task automatic checkCtrl(input string name, input resolvedCtrlT e, input resolvedCtrlT got,
                         input resolvedCtrlT mask);
    if ((got & mask) !== (e & mask)) begin
        $display("Error %s/%s: expected %h, actual %h", currentTest, name, e & mask, got & mask);
        testErrors++;
    end
endtask

task automatic finishTest();
    $display("%s: done, %0d errors", currentTest, testErrors);
    totalErrors += testErrors;
    testsRun++;
    testErrors = 0;
endtask

// offer one word, return once it has been taken on a rising edge
task automatic driveWord(input logic [31:0] word, input cmpFlagsT flags, output bit accepted);
    int waitCycles;
    accepted   = 1'b0;
    waitCycles = 0;
    @(negedge clk);
    inValid  = 1'b1;
    instr    = word;
    cmpFlags = flags;
    #1;
    while (!inReady && waitCycles < WaitLimit) begin
        @(negedge clk);
        #1;
        waitCycles++;
    end
    if (inReady) begin
        @(posedge clk);
        accepted = 1'b1;
    end
endtask

task automatic takeOutput(output resolvedCtrlT got, output bit seen);
    int waitCycles;
    seen       = 1'b0;
    got        = '0;
    waitCycles = 0;
    @(negedge clk);
    inValid  = 1'b0; // input already taken
    outReady = 1'b1;
    #1;
    while (!outValid && waitCycles < WaitLimit) begin
        @(negedge clk);
        #1;
        waitCycles++;
    end
    if (outValid) begin
        got  = outCtrl; // sampled mid-cycle
        seen = 1'b1;
        @(posedge clk);
    end
endtask

task automatic runOne(input string name, input logic [31:0] word, input cmpFlagsT flags,
                      input resolvedCtrlT e, input resolvedCtrlT mask);
    bit           ok;
    resolvedCtrlT got;
    driveWord(word, flags, ok);
    if (!ok) begin
        $display("%s/%s: input word was not accepted within %0d cycles",
                 currentTest, name, WaitLimit);
        testErrors++;
        @(negedge clk);
        inValid = 1'b0;
    end else begin
        takeOutput(got, ok);
        if (!ok) begin
            $display("%s/%s: no output bundle within %0d cycles", currentTest, name, WaitLimit);
            testErrors++;
        end else begin
            checkCtrl(name, e, got, mask);
        end
    end
endtask

task automatic testReset();
    currentTest = "reset";
    if (outValid !== 1'b0) begin
        $display("Error %s: outValid expected 0, actual %b", currentTest, outValid);
        testErrors++;
    end
    if (inReady !== 1'b1) begin
        $display("Error %s: inReady expected 1, actual %b", currentTest, inReady);
        testErrors++;
    end
    finishTest();
endtask

task automatic testDecode();
    int i;
    currentTest = "decode";
    for (i = 0; i < 9; i++) begin
        runOne(knownName[i], knownWord[i], '0, knownExp[i], fullMask);
    end
    finishTest();
endtask

task automatic testMemory();
    int i;
    currentTest = "memory";
    for (i = 9; i < 15; i++) begin
        runOne(knownName[i], knownWord[i], '0, knownExp[i], fullMask);
    end
    finishTest();
endtask

task automatic testBranches();
    int          rep;
    int          k;
    logic [31:0] randWord;
    logic [31:0] word;
    cmpFlagsT    flags;
    logic        taken;
    string       name;
    currentTest = "branch";
    for (rep = 0; rep < 2; rep++) begin
        for (k = 0; k < 6; k++) begin
            randWord = $random(seed);
            flags    = randWord[3:0];
            case (k)
                0: begin
                    name  = "beq";
                    word  = iWord(OpBeq, 5'd1, 5'd2, 16'h0008);
                    taken = flags.equalVal;
                end
                1: begin
                    name  = "bne";
                    word  = iWord(OpBne, 5'd1, 5'd2, 16'h0008);
                    taken = ~flags.equalVal;
                end
                2: begin
                    name  = "bgtz";
                    word  = iWord(OpBgtz, 5'd1, 5'd0, 16'h0010);
                    taken = flags.gtZero;
                end
                3: begin
                    name  = "blez";
                    word  = iWord(OpBlez, 5'd1, 5'd0, 16'h0010);
                    taken = ~flags.gtZero;
                end
                4: begin
                    name  = "bgez";
                    word  = iWord(OpRegimm, 5'd1, RtBgez, 16'h0020);
                    taken = ~flags.ltZero;
                end
                default: begin
                    name  = "bltz";
                    word  = iWord(OpRegimm, 5'd1, RtBltz, 16'h0020);
                    taken = flags.ltZero;
                end
            endcase
            runOne(name, word, flags, flowExpect(JmpNone, 1'b0, 1'b1, taken), flowMask);
        end
    end
    randWord = $random(seed);
    flags    = randWord[3:0];
    runOne("j", iWord(OpJ, 5'd0, 5'd0, 16'h0100), flags,
           flowExpect(JmpJ, 1'b0, 1'b0, 1'b0), flowMask);
    runOne("jal", iWord(OpJal, 5'd0, 5'd0, 16'h0100), flags,
           flowExpect(JmpLink, 1'b1, 1'b0, 1'b0), flowMask);
    runOne("jr", rWord(OpSpecial, 5'd31, 5'd0, 5'd0, 5'd0, FnJr), flags,
           flowExpect(JmpReg, 1'b0, 1'b1, 1'b0), flowMask); // pcSrc stays low
    finishTest();
endtask

task automatic testCondMoves();
    int          b;
    logic [31:0] randWord;
    cmpFlagsT    flags;
    currentTest = "condmove";
    for (b = 0; b < 2; b++) begin
        randWord   = $random(seed);
        flags      = randWord[3:0];
        flags.beqz = b[0];
        runOne($sformatf("movn beqz=%0d", b), rWord(OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, FnMovn),
               flags, flowExpect(JmpNone, ~flags.beqz, 1'b0, 1'b0), flowMask);
        runOne($sformatf("movz beqz=%0d", b), rWord(OpSpecial, 5'd1, 5'd2, 5'd3, 5'd0, FnMovz),
               flags, flowExpect(JmpNone, flags.beqz, 1'b0, 1'b0), flowMask);
    end
    finishTest();
endtask

task automatic testBackpressure();
    logic [31:0] randWord;
    int          idx;
    int          attempts;
    int          sent;
    int          waitCycles;
    bit          stalled;
    bit          pendingDone;
    int          expQ [$];   // table indices in send order
    currentTest = "backpressure";
    attempts    = 0;
    sent        = 0;
    stalled     = 1'b0;
    @(negedge clk);
    outReady = 1'b0;
    while (!stalled && attempts < 8) begin
        randWord = $random(seed);
        idx      = randWord % knownWord.size();
        @(negedge clk);
        inValid = 1'b1;
        instr   = knownWord[idx];
        #1;
        expQ.push_back(idx); // a refused word stays offered
        if (inReady) begin
            @(posedge clk);
            sent++;
        end else begin
            stalled = 1'b1;
        end
        attempts++;
    end
    if (!stalled) begin
        $display("%s: inReady never dropped after %0d words", currentTest, attempts);
        testErrors++;
    end else if (sent != 3) begin
        $display("Error %s: expected 3 words in flight, actual %0d", currentTest, sent);
        testErrors++;
    end
    pendingDone = !stalled;
    waitCycles  = 0;
    while (expQ.size() != 0 && waitCycles < WaitLimit) begin
        @(negedge clk);
        outReady = 1'b1;
        if (pendingDone) begin
            inValid = 1'b0;
        end
        #1;
        if (inValid && inReady) begin
            pendingDone = 1'b1; // held word goes in at the next edge
        end
        if (outValid) begin
            idx = expQ.pop_front();
            checkCtrl(knownName[idx], knownExp[idx], outCtrl, fullMask);
        end
        waitCycles++;
    end
    if (expQ.size() != 0) begin
        $display("%s: %0d bundles never arrived", currentTest, expQ.size());
        testErrors++;
    end
    @(negedge clk);
    inValid = 1'b0;
    for (waitCycles = 0; waitCycles < 4; waitCycles++) begin
        #1;
        if (outValid) begin
            $display("%s: an extra bundle appeared after the sequence", currentTest);
            testErrors++;
        end
        @(negedge clk);
    end
    finishTest();
endtask

// File: dv/tbMipsControl.sv
`timescale 1ns/1ps
module tbMipsControl;
    import mipsCtrlPkg::*;

    localparam int WaitLimit = 20; // cycles allowed per wait loop

    logic         clk;
    logic         rstN;
    logic         inValid;
    instrWordU    instr;
    logic         inReady;
    logic         outValid;
    logic         outReady;
    cmpFlagsT     cmpFlags;
    resolvedCtrlT outCtrl;

    integer seed = 12;
    int     testErrors = 0;   // errors in the running test
    int     totalErrors = 0;
    int     testsRun = 0;
    string  currentTest = "";

    // instructions whose bundle does not depend on the flags
    string        knownName [$];
    logic [31:0]  knownWord [$];
    resolvedCtrlT knownExp [$];
    resolvedCtrlT fullMask;
    resolvedCtrlT flowMask; // pc, branch, jump, write and memory bits

    clockGen clockGen_inst (
        .clk  (clk),
        .rstN (rstN)
    );

    mipsControlUnit mipsControlUnit_inst (
        .clk      (clk),
        .rstN     (rstN),
        .inValid  (inValid),
        .instr    (instr),
        .inReady  (inReady),
        .outValid (outValid),
        .outReady (outReady),
        .cmpFlags (cmpFlags),
        .outCtrl  (outCtrl)
    );

    `include "tbTests.svh"

    initial begin
        int waitCycles;
        inValid  = 1'b0;
        instr    = '0;
        outReady = 1'b1;
        cmpFlags = '0;
        loadKnownTable();
        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < WaitLimit) begin
            @(negedge clk);
            #1;
            waitCycles++;
        end
        if (rstN !== 1'b1) begin
            $display("reset was never released");
            totalErrors++;
        end else begin
            testReset();
            testDecode();
            testMemory();
            testBranches();
            testCondMoves();
            testBackpressure();
        end
        $display("tests run %0d, errors %0d", testsRun, totalErrors);
        if (totalErrors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end
endmodule

// File: filelist.f
+incdir+dv
source/mipsCtrlPkg.sv
source/instrDecoder.sv
source/ctrlQueue.sv
source/branchResolver.sv
source/mipsControlUnit.sv
dv/clockGen.sv
dv/tbMipsControl.sv

// File: run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps \
    -f filelist.f --top-module tbMipsControl -o simTb
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/simTb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
